/* Bender.yml */
package:
  name: core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/core_isa_pkg.sv
      - hdl/core_pipe_pkg.sv
      - hdl/reg_file.sv
      - hdl/operand_extend.sv
      - hdl/issue_stage.sv
      - hdl/execute_stage.sv
      - hdl/core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/core_properties.sv
      - verif/core_tb.sv

/* hdl/core_isa_pkg.sv */
`default_nettype none

`include "core_config.svh"

package core_isa_pkg;

	typedef logic [`CORE_XLEN-1:0]      word_t;     // data value or raw instruction
	typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;  // rn, rm, rd
	typedef logic [`CORE_SHAMT_W-1:0]   shamt_t;    // shift applied to rm

	// op field in bits 31..29
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,  // rn + b
		ALU_SUB = 3'd1,  // rn - b
		ALU_RSB = 3'd2,  // b - rn
		ALU_AND = 3'd3,
		ALU_ORR = 3'd4,
		ALU_EOR = 3'd5,
		ALU_MOV = 3'd6,  // b passes through
		ALU_MVN = 3'd7   // ~b
	} alu_op_e;

	// operand kind in bits 28..27 picks where operand b comes from
	typedef enum logic [1:0] {
		OPND_REG_SHIFT = 2'd0,  // R[rm] << shamt
		OPND_IMM8_S    = 2'd1,
		OPND_IMM12_U   = 2'd2,
		OPND_ZERO      = 2'd3   // constant zero
	} opnd_kind_e;

	// shamt (11..7), rm (3..0) and imm8 (7..0) all live inside imm12
	typedef struct packed {
		alu_op_e    op;     // 31..29
		opnd_kind_e kind;   // 28..27
		logic [6:0] rsvd;   // 26..20 ignored
		reg_idx_t   rn;     // 19..16
		reg_idx_t   rd;     // 15..12
		logic [`CORE_IMM12_W-1:0] imm12;  // 11..0
	} instr_t;

endpackage

`default_nettype wire

/* hdl/core_pipe_pkg.sv */
`default_nettype none

package core_pipe_pkg;

	import core_isa_pkg::*;

	// control that travels with an issued instruction
	typedef struct packed {
		logic       valid;  // low for a bubble
		alu_op_e    op;
		opnd_kind_e kind;
		shamt_t     shamt;
		reg_idx_t   rd;
	} issue_ctl_t;

	// one pending register write seen by the hazard check
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
	} dst_tag_t;

	// retire stream payload, also the register write
	typedef struct packed {
		reg_idx_t rd;
		word_t    value;
	} retire_t;

endpackage

`default_nettype wire

/* hdl/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   instr_valid,
	output logic                   instr_ready,
	input  core_isa_pkg::word_t    instr,
	output logic                   retire_valid,
	input  logic                   retire_ready,
	output core_pipe_pkg::retire_t retire
);

	core_isa_pkg::reg_idx_t    rd_idx_a;
	core_isa_pkg::reg_idx_t    rd_idx_b;
	core_isa_pkg::word_t       rd_data_a;
	core_isa_pkg::word_t       rd_data_b;
	core_isa_pkg::instr_t      cur_instr;  // held in issue register
	core_isa_pkg::word_t       imm;
	core_pipe_pkg::issue_ctl_t issue;
	core_pipe_pkg::dst_tag_t   ex_tag;
	core_pipe_pkg::dst_tag_t   wb_tag;
	logic                      advance;
	logic                      wr_en;
	core_isa_pkg::reg_idx_t    wr_idx;
	core_isa_pkg::word_t       wr_data;

	issue_stage issue0 (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.advance     (advance),
		.ex_tag      (ex_tag),
		.wb_tag      (wb_tag),
		.cur_instr   (cur_instr),
		.rd_idx_a    (rd_idx_a),
		.rd_idx_b    (rd_idx_b),
		.issue       (issue)
	);

	// register read and immediate build run side by side
	reg_file regs0 (
		.clk       (clk),
		.reset     (reset),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data)
	);

	operand_extend ext0 (
		.instr (cur_instr),
		.imm   (imm)
	);

	execute_stage exec0 (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.rd_data_a    (rd_data_a),
		.rd_data_b    (rd_data_b),
		.imm          (imm),
		.advance      (advance),
		.ex_tag       (ex_tag),
		.wb_tag       (wb_tag),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire       (retire),
		.wr_en        (wr_en),
		.wr_idx       (wr_idx),
		.wr_data      (wr_data)
	);

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  core_pipe_pkg::issue_ctl_t issue,
	input  core_isa_pkg::word_t       rd_data_a,  // R[rn]
	input  core_isa_pkg::word_t       rd_data_b,  // R[rm]
	input  core_isa_pkg::word_t       imm,
	output logic                      advance,
	output core_pipe_pkg::dst_tag_t   ex_tag,
	output core_pipe_pkg::dst_tag_t   wb_tag,
	output logic                      retire_valid,
	input  logic                      retire_ready,
	output core_pipe_pkg::retire_t    retire,
	output logic                      wr_en,
	output core_isa_pkg::reg_idx_t    wr_idx,
	output core_isa_pkg::word_t       wr_data
);

	import core_isa_pkg::*;
	import core_pipe_pkg::*;

	issue_ctl_t ex_ctl;     // execute register control
	word_t      ex_a;       // operand payload, no reset
	word_t      ex_b;
	word_t      ex_imm;
	word_t      opnd_b;
	word_t      alu_out;
	logic       res_valid;  // result register full
	retire_t    res;

	// whole pipe moves only when the result slot frees up
	assign advance = !res_valid || retire_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_ctl    <= '0;
			res_valid <= 1'b0;
		end else if (advance) begin
			ex_ctl    <= issue;         // bubble comes in with valid low
			res_valid <= ex_ctl.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && issue.valid) begin
			ex_a   <= rd_data_a;
			ex_b   <= rd_data_b;
			ex_imm <= imm;
		end
		if (advance && ex_ctl.valid) begin
			res.rd    <= ex_ctl.rd;
			res.value <= alu_out;
		end
	end

	// operand b, shifted rm or the extended immediate
	assign opnd_b = (ex_ctl.kind == OPND_REG_SHIFT) ? (ex_b << ex_ctl.shamt) : ex_imm;

	always_comb begin
		case (ex_ctl.op)
			ALU_ADD: alu_out = ex_a + opnd_b;
			ALU_SUB: alu_out = ex_a - opnd_b;
			ALU_RSB: alu_out = opnd_b - ex_a;  // reversed
			ALU_AND: alu_out = ex_a & opnd_b;
			ALU_ORR: alu_out = ex_a | opnd_b;
			ALU_EOR: alu_out = ex_a ^ opnd_b;
			ALU_MOV: alu_out = opnd_b;
			default: alu_out = ~opnd_b;        // ALU_MVN
		endcase
	end

	// pending destinations for the hazard check
	assign ex_tag.valid = ex_ctl.valid;
	assign ex_tag.rd    = ex_ctl.rd;
	assign wb_tag.valid = res_valid;
	assign wb_tag.rd    = res.rd;

	assign retire_valid = res_valid;
	assign retire       = res;  // held until the transfer

	// register write on the retire transfer edge
	assign wr_en   = res_valid && retire_ready;
	assign wr_idx  = res.rd;
	assign wr_data = res.value;

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     instr_valid,
	output logic                     instr_ready,
	input  core_isa_pkg::word_t      instr,
	input  logic                     advance,    // execute can take a packet this edge
	input  core_pipe_pkg::dst_tag_t  ex_tag,     // write pending in execute register
	input  core_pipe_pkg::dst_tag_t  wb_tag,     // write pending in result register
	output core_isa_pkg::instr_t     cur_instr,
	output core_isa_pkg::reg_idx_t   rd_idx_a,
	output core_isa_pkg::reg_idx_t   rd_idx_b,
	output core_pipe_pkg::issue_ctl_t issue
);

	import core_isa_pkg::*;
	import core_pipe_pkg::*;

	logic     hold_valid;  // issue register occupied
	instr_t   hold_instr;  // payload, no reset
	reg_idx_t src_a;       // rn
	reg_idx_t src_b;       // rm
	logic     use_b;       // rm only read in register-shift kind
	logic     haz_a;
	logic     haz_b;
	logic     hazard;
	logic     go;          // instruction leaves this cycle
	logic     accept;

	assign src_a = hold_instr.rn;
	assign src_b = hold_instr.imm12[3:0];
	assign use_b = (hold_instr.kind == OPND_REG_SHIFT);

	// read-after-write check against both in-flight results
	assign haz_a = (ex_tag.valid && ex_tag.rd == src_a) ||
	               (wb_tag.valid && wb_tag.rd == src_a);
	assign haz_b = use_b && ((ex_tag.valid && ex_tag.rd == src_b) ||
	                         (wb_tag.valid && wb_tag.rd == src_b));
	assign hazard = haz_a || haz_b;

	assign go          = hold_valid && advance && !hazard;
	assign instr_ready = !hold_valid || go;  // empty or draining now
	assign accept      = instr_valid && instr_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (instr_ready) begin
			hold_valid <= instr_valid;  // refill, or go empty after issuing
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			hold_instr <= instr_t'(instr);
		end
	end

	// register file addresses follow the held instruction
	assign rd_idx_a  = src_a;
	assign rd_idx_b  = src_b;
	assign cur_instr = hold_instr;  // operand_extend works off this

	// bubble whenever nothing leaves
	always_comb begin
		issue.valid = go;
		issue.op    = hold_instr.op;
		issue.kind  = hold_instr.kind;
		issue.shamt = hold_instr.imm12[11:7];
		issue.rd    = hold_instr.rd;
	end

endmodule

`default_nettype wire

/* hdl/operand_extend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module operand_extend (
	input  core_isa_pkg::instr_t instr,
	output core_isa_pkg::word_t  imm
);

	import core_isa_pkg::*;

	logic [`CORE_IMM8_W-1:0]  imm8;   // low byte of the instruction
	logic [`CORE_IMM12_W-1:0] imm12;

	assign imm12 = instr.imm12;
	assign imm8  = instr.imm12[`CORE_IMM8_W-1:0];

	always_comb begin
		case (instr.kind)
			OPND_IMM8_S:
				imm = {{(`CORE_XLEN-`CORE_IMM8_W){imm8[`CORE_IMM8_W-1]}}, imm8};  // sign fill
			OPND_IMM12_U:
				imm = {{(`CORE_XLEN-`CORE_IMM12_W){1'b0}}, imm12};  // zero fill
			default:
				// register kind gets its operand from the shifter in execute
				// zero kind is literally zero
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 reset,
	input  core_isa_pkg::reg_idx_t rd_idx_a,  // rn
	input  core_isa_pkg::reg_idx_t rd_idx_b,  // rm
	output core_isa_pkg::word_t  rd_data_a,
	output core_isa_pkg::word_t  rd_data_b,
	input  logic                 wr_en,
	input  core_isa_pkg::reg_idx_t wr_idx,
	input  core_isa_pkg::word_t  wr_data
);

	import core_isa_pkg::*;

	word_t regs [`CORE_NREGS];  // r0..r15

	// single write port that lands on the retire edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;  // all registers read zero after reset
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// two read ports without bypass
	// a write lands on the edge and readers see it the cycle after
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

/* include/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath width, one register or instruction word
`define CORE_XLEN       32

// register file shape, all sixteen are general purpose
`define CORE_NREGS      16
`define CORE_REG_IDX_W  4

// left shift of rm in register-shift kind
`define CORE_SHAMT_W    5

// immediate fields as they sit in the low instruction bits
`define CORE_IMM8_W     8   // sign-extended
`define CORE_IMM12_W    12  // zero-extended

`endif

/* verif/core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module core_properties (
	input logic                   clk,
	input logic                   reset,
	input logic                   instr_valid,
	input logic                   instr_ready,
	input core_isa_pkg::word_t    instr,
	input logic                   retire_valid,
	input logic                   retire_ready,
	input core_pipe_pkg::retire_t retire
);

	int assert_fails = 0;  // read by the testbench at the end

	// retire payload frozen while the sink stalls
	retire_held: assert property (@(posedge clk) disable iff (reset)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire))
		else begin
			assert_fails++;
			$error("retire dropped or changed while retire_ready was low");
		end

	// source side keeps its word until the core takes it
	instr_held: assert property (@(posedge clk) disable iff (reset)
		instr_valid && !instr_ready |=> instr_valid && $stable(instr))
		else begin
			assert_fails++;
			$error("instr dropped or changed before it was accepted");
		end

	no_retire_in_reset: assert property (@(posedge clk) reset |-> !retire_valid)
		else begin
			assert_fails++;
			$error("retire_valid high during reset");
		end

endmodule

`default_nettype wire

/* verif/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_tb;

	import core_isa_pkg::*;
	import core_pipe_pkg::*;

	localparam int N_INSTR     = 32 + 48 + 24 + 60 + 80 + 300;  // sum over all tests
	localparam int CYCLE_LIMIT = N_INSTR * 12 + 200;

	logic     clk;
	logic     reset;
	logic     instr_valid;
	logic     instr_ready;
	word_t    instr;
	logic     retire_valid;
	logic     retire_ready;
	retire_t  retire;

	int       seed = 32'h7197_3cab;
	int       rr_seed;                   // separate stream for retire_ready
	logic     rr_random;                 // random back-pressure on
	logic     gaps;                      // random idle cycles between instructions
	word_t    model_regs [`CORE_NREGS];  // program order as of the last acceptance
	word_t    ret_regs [`CORE_NREGS];    // rebuilt from the retire stream
	retire_t  exp_q [$];
	reg_idx_t last_rd;
	int       errors;
	int       test_base;
	int       accepted;
	int       retired;
	int       cycles;
	word_t    w;

	core_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire       (retire)
	);

	bind core_top core_properties props0 (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire       (retire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	function automatic word_t encode(logic [2:0] op, logic [1:0] kind, reg_idx_t rn,
			reg_idx_t rd, logic [11:0] imm12);
		return {op, kind, 7'd0, rn, rd, imm12};
	endfunction

	// result of one instruction against the program-order register state
	function automatic word_t model_result(word_t iw);
		word_t a;
		word_t b;
		a = model_regs[iw[19:16]];
		case (iw[28:27])
			2'd0: b = model_regs[iw[3:0]] << iw[11:7];  // rm shifted left
			2'd1: b = {{24{iw[7]}}, iw[7:0]};
			2'd2: b = {20'd0, iw[11:0]};
			default: b = '0;
		endcase
		case (iw[31:29])
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_RSB: return b - a;
			ALU_AND: return a & b;
			ALU_ORR: return a | b;
			ALU_EOR: return a ^ b;
			ALU_MOV: return b;
			default: return ~b;
		endcase
	endfunction

	// dep forces a read of the latest destination and a coin flip may too
	function automatic word_t rand_instr(logic dep);
		word_t r;
		r = $random(seed);
		if (dep || r[26]) begin
			r[15:14] = 2'b00;            // rd in r0..r3 keeps chains short
			r[19:16] = last_rd;
			r[3:0]   = {2'b00, r[5:4]};  // rm in the same window
		end
		r[26:20] = '0;
		last_rd  = r[15:12];
		return r;
	endfunction

	task automatic check(string name, word_t got, word_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error @ %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// starts and ends on a falling edge
	task automatic send(word_t iw);
		int gap;
		instr_valid = 1'b1;
		instr       = iw;
		@(posedge clk);
		while (!instr_ready) begin
			@(posedge clk);
		end
		@(negedge clk);
		instr_valid = 1'b0;
		if (gaps) begin
			gap = $random(seed) & 3;
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic finish_test(string name);
		drain();
		$display("test %-16s %s, %0d errors", name,
			(errors == test_base) ? "ok" : "failed", errors - test_base);
		test_base = errors;
	endtask

	// retire side is handled first so a stray retire never pops a fresh entry
	always @(posedge clk) begin
		retire_t e;
		if (!reset) begin
			if (retire_valid && retire_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("retire at %0t ns with no instruction outstanding", $time);
				end else begin
					e = exp_q.pop_front();
					check("retire.rd", retire.rd, e.rd);
					check("retire.value", retire.value, e.value);
				end
				ret_regs[retire.rd] = retire.value;
				retired++;
			end
			if (instr_valid && instr_ready) begin
				e.rd    = instr[15:12];
				e.value = model_result(instr);
				model_regs[e.rd] = e.value;
				exp_q.push_back(e);
				accepted++;
			end
		end
	end

	always @(negedge clk) begin
		retire_ready = rr_random ? (($random(rr_seed) & 3) != 0) : 1'b1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles, %0d of %0d retired",
				CYCLE_LIMIT, retired, accepted);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		reset        = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		retire_ready = 1'b1;
		rr_random    = 1'b0;
		gaps         = 1'b0;
		errors       = 0;
		test_base    = 0;
		accepted     = 0;
		retired      = 0;
		cycles       = 0;
		last_rd      = '0;
		for (int i = 0; i < `CORE_NREGS; i++) begin
			model_regs[i] = '0;
			ret_regs[i]   = '0;
		end
		rr_seed = $random(seed);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// reset values read back first and then cleared with zero kind
		check("retire_valid", retire_valid, 1'b0);
		check("instr_ready", instr_ready, 1'b1);
		for (int i = 0; i < 16; i++) begin
			send(encode(ALU_ORR, OPND_ZERO, i[3:0], i[3:0], 12'h000));
		end
		for (int i = 0; i < 16; i++) begin
			send(encode(ALU_MOV, OPND_ZERO, 4'd0, i[3:0], 12'h000));
		end
		finish_test("reset state");

		for (int i = 0; i < 16; i++) begin
			w = $random(seed);
			send(encode(ALU_MVN, OPND_IMM12_U, 4'd0, i[3:0], w[11:0]));  // nonzero fill
		end
		for (int op = 0; op < 8; op++) begin
			for (int k = 0; k < 4; k++) begin
				w = $random(seed);
				send(encode(op[2:0], OPND_REG_SHIFT, w[19:16], w[15:12], w[11:0]));
			end
		end
		finish_test("register ops");

		send(encode(ALU_MOV, OPND_IMM8_S, 4'd0, 4'd1, 12'h080));   // most negative imm8
		send(encode(ALU_MOV, OPND_IMM12_U, 4'd0, 4'd2, 12'h800));  // top bit of imm12
		for (int k = 0; k < 11; k++) begin
			w = $random(seed);
			w[7] = k[0];
			send(encode(w[31:29], OPND_IMM8_S, w[19:16], w[15:12], w[11:0]));
			w[11] = 1'b1;
			send(encode(w[31:29], OPND_IMM12_U, w[19:16], w[27:24], w[11:0]));
		end
		finish_test("immediates");

		for (int k = 0; k < 60; k++) begin
			send(rand_instr(1'b1));
		end
		finish_test("dependent chains");

		rr_random = 1'b1;
		gaps      = 1'b1;
		for (int k = 0; k < 80; k++) begin
			send(rand_instr(1'b0));
		end
		finish_test("back-pressure");

		for (int k = 0; k < 300; k++) begin
			gaps = k[5];  // bursts with and without idle cycles
			send(rand_instr(1'b0));
		end
		drain();
		repeat (16) @(negedge clk);  // a late duplicate retire would land here
		check("retired count", retired, accepted);
		for (int i = 0; i < `CORE_NREGS; i++) begin
			check($sformatf("r%0d after run", i), ret_regs[i], model_regs[i]);
		end
		finish_test("long mixed run");
		rr_random = 1'b0;

		errors += dut0.props0.assert_fails;
		$display("done: %0d accepted, %0d retired, %0d errors", accepted, retired, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/core_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/reg_file.sv
hdl/operand_extend.sv
hdl/issue_stage.sv
hdl/execute_stage.sv
hdl/core_top.sv
verif/core_properties.sv
verif/core_tb.sv
